//--- hw/alu.sv
module alu (
    input  cpu_pkg::data_t   a,       // Operand a, register a
    input  cpu_pkg::data_t   b,       // Operand b, selected upstream
    input  cpu_pkg::alu_op_e op,      // Operation
    output cpu_pkg::data_t   result,  // Modulo 256 result
    output logic             zero     // Result is zero
);

    import cpu_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;  // Carry dropped
            ALU_SUB:    result = a - b;  // Borrow dropped
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_PASS_B: result = b;      // LI and BZ test
            default:    result = '0;
        endcase
    end

    // Used by BZ with b = r1
    assign zero = (result == '0);

endmodule

//--- hw/control_decoder.sv
module control_decoder (
    input  cpu_pkg::instr_t instruction,  // Current instruction
    input  logic            running,      // Core in ST_RUN
    output cpu_pkg::ctrl_t  ctrl          // Qualified control
);

    import cpu_pkg::*;

    opcode_e opcode;   // Bits 8..6
    logic    sys_bit;  // Bit 5, splits BZ from HALT

    assign opcode  = opcode_e'(instruction[8:6]);
    assign sys_bit = instruction[5];

    always_comb begin
        // Field split, always present
        ctrl.r_a         = instruction[5:4];
        ctrl.r_b         = instruction[3:2];
        ctrl.imm         = {{2{instruction[5]}}, instruction[5:0]};  // Sign extend 6 to 8
        ctrl.br_off      = {{3{instruction[4]}}, instruction[4:0]};  // Sign extend 5 to 8
        // Safe defaults
        ctrl.alu_op      = ALU_ADD;
        ctrl.use_imm     = 1'b0;
        ctrl.branch_test = 1'b0;
        ctrl.reg_we      = 1'b0;
        ctrl.wsel        = instruction[5:4];  // r_a unless overridden
        ctrl.mem_we      = 1'b0;
        ctrl.mem_to_reg  = 1'b0;
        ctrl.branch      = 1'b0;
        ctrl.halt        = 1'b0;

        case (opcode)
            OP_ADD: begin
                ctrl.alu_op = ALU_ADD;
                ctrl.reg_we = 1'b1;  // r_a gets result
            end
            OP_SUB: begin
                ctrl.alu_op = ALU_SUB;
                ctrl.reg_we = 1'b1;
            end
            OP_AND: begin
                ctrl.alu_op = ALU_AND;
                ctrl.reg_we = 1'b1;
            end
            OP_OR: begin
                ctrl.alu_op = ALU_OR;
                ctrl.reg_we = 1'b1;
            end
            OP_LI: begin
                ctrl.alu_op  = ALU_PASS_B;  // Immediate straight through
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
                ctrl.wsel    = 2'd1;        // Always r1
            end
            OP_LD: begin
                ctrl.reg_we     = 1'b1;
                ctrl.wsel       = instruction[3:2];  // r_b gets mem[r_a]
                ctrl.mem_to_reg = 1'b1;
            end
            OP_ST: begin
                ctrl.mem_we = 1'b1;  // mem[r_a] gets r_b
            end
            OP_SYS: begin
                if (sys_bit) begin
                    ctrl.halt = 1'b1;
                end else begin
                    ctrl.alu_op      = ALU_PASS_B;  // Zero flag tests r1
                    ctrl.branch_test = 1'b1;
                    ctrl.branch      = 1'b1;
                end
            end
            default: ctrl.alu_op = ALU_ADD;
        endcase

        // Nothing retires outside ST_RUN
        ctrl.reg_we = ctrl.reg_we & running;
        ctrl.mem_we = ctrl.mem_we & running;
        ctrl.branch = ctrl.branch & running;
        ctrl.halt   = ctrl.halt & running;
    end

endmodule

//--- hw/cpu_pkg.sv
package cpu_pkg;

    localparam int DATA_W    = 8;  // Register and memory word
    localparam int ADDR_W    = 8;  // Data memory address
    localparam int PC_W      = 8;  // Program counter
    localparam int INSTR_W   = 9;  // One instruction word
    localparam int REG_IDX_W = 2;  // Four registers

    typedef logic [DATA_W-1:0]    data_t;     // Register and memory data
    typedef logic [ADDR_W-1:0]    addr_t;     // Data memory address
    typedef logic [PC_W-1:0]      pc_t;       // Program counter, instruction address
    typedef logic [INSTR_W-1:0]   instr_t;    // Raw instruction
    typedef logic [REG_IDX_W-1:0] reg_idx_t;  // Register number

    // Opcode field, bits 8..6 of the instruction
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,  // r_a = r_a + r_b
        OP_SUB = 3'd1,  // r_a = r_a - r_b
        OP_AND = 3'd2,  // r_a = r_a & r_b
        OP_OR  = 3'd3,  // r_a = r_a | r_b
        OP_LI  = 3'd4,  // r1 = sext(imm6)
        OP_LD  = 3'd5,  // r_b = mem[r_a]
        OP_ST  = 3'd6,  // mem[r_a] = r_b
        OP_SYS = 3'd7   // BZ with bit 5 clear, HALT with bit 5 set
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASS_B      // Result is operand b
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,        // After reset, program load allowed
        ST_RUN,         // One instruction per clock
        ST_HALTED       // HALT retired, done high
    } run_state_e;

    // Decoded control for one instruction
    typedef struct packed {
        alu_op_e  alu_op;       // ALU operation
        logic     use_imm;      // Operand b from immediate
        logic     branch_test;  // Operand b from r1 for BZ
        logic     reg_we;       // Register write, qualified
        reg_idx_t wsel;         // Destination register
        logic     mem_we;       // Data memory write, qualified
        logic     mem_to_reg;   // Write back memory data
        logic     branch;       // BZ, qualified
        logic     halt;         // HALT, qualified
        reg_idx_t r_a;          // Bits 5..4
        reg_idx_t r_b;          // Bits 3..2
        data_t    imm;          // Sign-extended bits 5..0
        pc_t      br_off;       // Sign-extended bits 4..0
    } ctrl_t;

endpackage

//--- hw/cpu_top.sv
module cpu_top #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,       // Run pulse
    input  logic            prog_we,     // Program load strobe
    input  cpu_pkg::pc_t    prog_addr,   // Program load address
    input  cpu_pkg::instr_t prog_data,   // Program load word
    input  cpu_pkg::addr_t  host_addr,   // Result read address
    output logic            done,        // High while halted
    output cpu_pkg::data_t  host_rdata   // Result read data
);

    import cpu_pkg::*;

    pc_t    pc;           // Fetch address
    instr_t instruction;  // Current instruction
    ctrl_t  ctrl;         // Decoded, qualified control
    logic   running;      // Core executing
    logic   clear;        // Register clear pulse
    logic   load_ok;      // Host load window
    logic   zero;         // ALU zero flag
    data_t  data_a;       // Register r_a
    data_t  data_b;       // Register r_b
    data_t  data_r1;      // Register r1
    data_t  alu_b;        // Selected ALU operand b
    data_t  alu_result;   // ALU output
    data_t  mem_rdata;    // Load data
    data_t  wb_data;      // Register write-back value

    run_control i_run_control (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .halt    (ctrl.halt),
        .branch  (ctrl.branch),
        .zero    (zero),
        .br_off  (ctrl.br_off),
        .pc      (pc),
        .running (running),
        .clear   (clear),
        .load_ok (load_ok),
        .done    (done)
    );

    instruction_memory #(.IMEM_DEPTH(IMEM_DEPTH)) i_instruction_memory (
        .clk         (clk),
        .we          (prog_we & load_ok),  // Loads ignored while running
        .waddr       (prog_addr),
        .wdata       (prog_data),
        .pc          (pc),
        .instruction (instruction)
    );

    control_decoder i_control_decoder (
        .instruction (instruction),
        .running     (running),
        .ctrl        (ctrl)
    );

    register_file i_register_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (clear),
        .ra      (ctrl.r_a),
        .rb      (ctrl.r_b),
        .we      (ctrl.reg_we),
        .wsel    (ctrl.wsel),
        .wdata   (wb_data),
        .data_a  (data_a),
        .data_b  (data_b),
        .data_r1 (data_r1)
    );

    // Operand b is the immediate for LI, r1 for BZ, else r_b
    assign alu_b = ctrl.use_imm ? ctrl.imm : (ctrl.branch_test ? data_r1 : data_b);

    alu i_alu (
        .a      (data_a),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .zero   (zero)
    );

    data_memory #(.DMEM_DEPTH(DMEM_DEPTH)) i_data_memory (
        .clk        (clk),
        .we         (ctrl.mem_we),
        .addr       (data_a),       // Address from r_a
        .wdata      (data_b),       // Store data from r_b
        .rdata      (mem_rdata),
        .host_addr  (host_addr),
        .host_rdata (host_rdata)
    );

    assign wb_data = ctrl.mem_to_reg ? mem_rdata : alu_result;  // LD or ALU

endmodule

//--- hw/data_memory.sv
module data_memory #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic           clk,
    input  logic           we,          // Core store, qualified
    input  cpu_pkg::addr_t addr,        // Core address from r_a
    input  cpu_pkg::data_t wdata,       // Store data from r_b
    output cpu_pkg::data_t rdata,       // Load data
    input  cpu_pkg::addr_t host_addr,   // Host read address
    output cpu_pkg::data_t host_rdata   // Host read data
);

    import cpu_pkg::*;

    localparam int AW = $clog2(DMEM_DEPTH);  // Index bits actually used

    data_t mem [DMEM_DEPTH];  // Keeps contents across runs

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr[AW-1:0]] <= wdata;  // Store retires at the edge
        end
    end

    // Two asynchronous read ports
    assign rdata      = mem[addr[AW-1:0]];       // Core load
    assign host_rdata = mem[host_addr[AW-1:0]];  // Result readback

endmodule

//--- hw/instruction_memory.sv
module instruction_memory #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic            clk,
    input  logic            we,           // Host write, already qualified
    input  cpu_pkg::pc_t    waddr,        // Host write address
    input  cpu_pkg::instr_t wdata,        // Host write data
    input  cpu_pkg::pc_t    pc,           // Fetch address
    output cpu_pkg::instr_t instruction   // Fetched word, same cycle
);

    import cpu_pkg::*;

    localparam int AW = $clog2(IMEM_DEPTH);  // Index bits actually used

    instr_t mem [IMEM_DEPTH];  // Program store, no reset

    // Host load port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[AW-1:0]] <= wdata;  // Upper address bits dropped
        end
    end

    // Asynchronous fetch
    assign instruction = mem[pc[AW-1:0]];  // Wraps on smaller depth

endmodule

//--- hw/register_file.sv
module register_file (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clear,    // Start pulse, zeroes all registers
    input  cpu_pkg::reg_idx_t ra,       // Read port a
    input  cpu_pkg::reg_idx_t rb,       // Read port b
    input  logic              we,       // Write enable
    input  cpu_pkg::reg_idx_t wsel,     // Write register
    input  cpu_pkg::data_t    wdata,    // Write data
    output cpu_pkg::data_t    data_a,   // Value of ra
    output cpu_pkg::data_t    data_b,   // Value of rb
    output cpu_pkg::data_t    data_r1   // Fixed r1 for BZ
);

    import cpu_pkg::*;

    data_t regs [4];  // r0..r3

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;  // Fresh register state per run
            end
        end else if (we) begin
            regs[wsel] <= wdata;  // Single write port
        end
    end

    // Combinational reads, old value until the edge
    assign data_a  = regs[ra];
    assign data_b  = regs[rb];
    assign data_r1 = regs[1];

endmodule

//--- hw/run_control.sv
module run_control (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,     // Host pulse
    input  logic         halt,      // HALT, qualified
    input  logic         branch,    // BZ, qualified
    input  logic         zero,      // ALU zero flag, r1 == 0 on BZ
    input  cpu_pkg::pc_t br_off,    // Sign-extended branch offset
    output cpu_pkg::pc_t pc,        // Fetch address
    output logic         running,   // State is ST_RUN
    output logic         clear,     // Register clear on accepted start
    output logic         load_ok,   // Program writes allowed
    output logic         done       // State is ST_HALTED
);

    import cpu_pkg::*;

    run_state_e state;        // Run FSM
    pc_t        pc_plus1;     // Sequential successor
    pc_t        next_pc;      // Selected successor
    logic       take_branch;  // BZ with r1 zero
    logic       start_ok;     // Start outside ST_RUN

    assign load_ok  = (state != ST_RUN);   // Idle or halted
    assign start_ok = start & load_ok;     // Start while running ignored
    assign clear    = start_ok;            // One cycle, follows start
    assign running  = (state == ST_RUN);
    assign done     = (state == ST_HALTED);

    // Next PC selection
    assign take_branch = branch & zero;
    assign pc_plus1    = pc + pc_t'(1);
    assign next_pc     = take_branch ? pc_plus1 + br_off : pc_plus1;  // Wraps at 256

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            pc    <= '0;
        end else begin
            case (state)
                ST_IDLE, ST_HALTED: begin
                    if (start_ok) begin
                        state <= ST_RUN;  // Run from this edge
                        pc    <= '0;      // Program always starts at 0
                    end
                end
                ST_RUN: begin
                    if (halt) begin
                        state <= ST_HALTED;  // done rises here, PC holds
                    end else begin
                        pc <= next_pc;       // One instruction retired
                    end
                end
                default: begin
                    state <= ST_IDLE;  // Unused encoding
                end
            endcase
        end
    end

endmodule

//--- project.f
hw/cpu_pkg.sv
hw/instruction_memory.sv
hw/control_decoder.sv
hw/register_file.sv
hw/alu.sv
hw/data_memory.sv
hw/run_control.sv
hw/cpu_top.sv
testbench/tb_clock.sv
testbench/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cpu_tb simulation with Verilator

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing -f project.f --top-module cpu_tb -o cpu_tb_sim \
        > "$BUILD_LOG" 2>&1; then
    cat "$BUILD_LOG"
    echo "Build failed, see $BUILD_LOG"
    exit 1
fi

if ! ./obj_dir/cpu_tb_sim > "$SIM_LOG" 2>&1; then
    cat "$SIM_LOG"
    echo "Simulation did not run to completion, see $SIM_LOG"
    exit 1
fi

cat "$SIM_LOG"

if grep -q "Something failed" "$SIM_LOG"; then
    exit 1
fi

exit 0

//--- testbench/cpu_tb.sv
module cpu_tb;

    import cpu_pkg::*;

    localparam instr_t HALT_WORD = {OP_SYS, 6'b100000};  // SYS with bit 5 set

    logic   clk;
    logic   rst_n;
    logic   start;
    logic   prog_we;
    pc_t    prog_addr;
    instr_t prog_data;
    addr_t  host_addr;
    logic   done;
    data_t  host_rdata;
    int     errors = 0;  // Failed checks and timeouts
    instr_t prog[$];     // Program under construction

    tb_clock i_tb_clock (.clk(clk));

    cpu_top #(.IMEM_DEPTH(256), .DMEM_DEPTH(256)) i_cpu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .host_addr  (host_addr),
        .done       (done),
        .host_rdata (host_rdata)
    );

    // Two-register instruction word
    function automatic instr_t rr_word(opcode_e op, reg_idx_t ra, reg_idx_t rb);
        return {op, ra, rb, 2'b00};
    endfunction

    function automatic instr_t bz_word(logic [4:0] off);
        return {OP_SYS, 1'b0, off};  // Bit 5 clear
    endfunction

    // LI value as it lands in r1
    function automatic data_t sext6(logic [5:0] v);
        return {{2{v[5]}}, v};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;  // Drive point after the edge
    endtask

    task automatic check_data(string name, data_t got, data_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // Host read, sampled at the falling edge
    task automatic check_mem(addr_t a, data_t exp);
        next_cycle();
        host_addr = a;
        @(negedge clk);
        check_data($sformatf("host_rdata[%0d]", a), host_rdata, exp);
    endtask

    // r = sext(v), clobbers r1
    task automatic put_set_reg(reg_idx_t r, logic [5:0] v);
        prog.push_back({OP_LI, v});
        prog.push_back(rr_word(OP_SUB, r, r));     // Target to zero
        prog.push_back(rr_word(OP_ADD, r, 2'd1));  // Target = r1
    endtask

    // mem[addr] = a op b, using r0, r2, r3
    task automatic append_op_store(opcode_e op, logic [5:0] a, logic [5:0] b,
                                   logic [5:0] addr);
        put_set_reg(2'd2, a);
        put_set_reg(2'd3, b);
        prog.push_back(rr_word(op, 2'd2, 2'd3));
        put_set_reg(2'd0, addr);
        prog.push_back(rr_word(OP_ST, 2'd0, 2'd2));
    endtask

    // Count n iterations into r2, then mem[addr] = r2
    task automatic build_count_loop(logic [5:0] n, logic [5:0] addr);
        int top;
        put_set_reg(2'd3, 6'd1);  // Step of one
        put_set_reg(2'd0, n);     // Loop counter
        top = prog.size();
        prog.push_back(rr_word(OP_ADD, 2'd2, 2'd3));  // One more iteration
        prog.push_back(rr_word(OP_SUB, 2'd0, 2'd3));
        prog.push_back(rr_word(OP_SUB, 2'd1, 2'd1));
        prog.push_back(rr_word(OP_ADD, 2'd1, 2'd0));  // r1 follows counter
        prog.push_back(bz_word(5'd2));                // Exit at zero
        prog.push_back(rr_word(OP_SUB, 2'd1, 2'd1));  // Make back jump taken
        prog.push_back(bz_word(5'(top - prog.size() - 1)));
        put_set_reg(2'd0, addr);
        prog.push_back(rr_word(OP_ST, 2'd0, 2'd2));
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            next_cycle();
            prog_we   = 1'b1;
            prog_addr = pc_t'(i);
            prog_data = prog[i];
        end
        next_cycle();
        prog_we = 1'b0;
    endtask

    task automatic pulse_start();
        next_cycle();
        start = 1'b1;
        next_cycle();
        start = 1'b0;  // Accepted at the edge just passed
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < 2000) begin
            next_cycle();
            cycles++;
        end
        if (!done) begin
            $display("timeout at %0t: done did not rise within 2000 cycles", $time);
            errors++;
        end
    endtask

    task automatic run_program();
        pulse_start();
        wait_done();
    endtask

    task automatic reset_and_halt();
        check_flag("done", done, 1'b0);
        prog.delete();
        prog.push_back(HALT_WORD);
        load_program();
        check_flag("done", done, 1'b0);  // Still idle
        run_program();
        check_flag("done", done, 1'b1);
        repeat (3) begin
            next_cycle();
            check_flag("done", done, 1'b1);
        end
        pulse_start();
        check_flag("done", done, 1'b0);  // Single run cycle
        wait_done();
        repeat (3) begin
            next_cycle();
            check_flag("done", done, 1'b1);
        end
    endtask

    task automatic arithmetic_ops();
        logic [5:0] a;
        logic [5:0] b;
        a = 6'h39;  // -7
        b = 6'd13;
        prog.delete();
        append_op_store(OP_ADD, a, b, 6'd1);
        append_op_store(OP_SUB, a, b, 6'd2);
        append_op_store(OP_AND, a, b, 6'd3);
        append_op_store(OP_OR, a, b, 6'd4);
        prog.push_back(HALT_WORD);
        load_program();
        run_program();
        check_mem(8'd1, sext6(a) + sext6(b));
        check_mem(8'd2, sext6(a) - sext6(b));
        check_mem(8'd3, sext6(a) & sext6(b));
        check_mem(8'd4, sext6(a) | sext6(b));
    endtask

    task automatic memory_copy();
        prog.delete();
        put_set_reg(2'd0, 6'd10);
        prog.push_back({OP_LI, 6'h2D});               // r1 = -19
        prog.push_back(rr_word(OP_ST, 2'd0, 2'd1));   // mem[10] = r1
        prog.push_back(rr_word(OP_LD, 2'd0, 2'd3));   // r3 = mem[10]
        put_set_reg(2'd0, 6'd11);
        prog.push_back(rr_word(OP_ST, 2'd0, 2'd3));
        prog.push_back(HALT_WORD);
        load_program();
        run_program();
        check_mem(8'd10, sext6(6'h2D));
        check_mem(8'd11, sext6(6'h2D));
    endtask

    task automatic branch_loop();
        prog.delete();
        put_set_reg(2'd0, 6'd17);
        prog.push_back(rr_word(OP_ST, 2'd0, 2'd2));  // Known old value, r2 is 0
        build_count_loop(6'd5, 6'd16);
        prog.push_back(rr_word(OP_SUB, 2'd1, 2'd1));
        prog.push_back(bz_word(5'd4));               // Skip the next store
        put_set_reg(2'd0, 6'd17);
        prog.push_back(rr_word(OP_ST, 2'd0, 2'd2));
        prog.push_back(HALT_WORD);
        load_program();
        run_program();
        check_mem(8'd16, 8'd5);
        check_mem(8'd17, 8'd0);
    endtask

    task automatic restart_clear();
        prog.delete();
        prog.push_back({OP_LI, 6'd7});
        prog.push_back(rr_word(OP_ADD, 2'd2, 2'd1));  // Leaves r2 = 7
        prog.push_back(rr_word(OP_ADD, 2'd3, 2'd1));  // Leaves r3 = 7
        prog.push_back({OP_LI, 6'd24});
        prog.push_back(rr_word(OP_ADD, 2'd0, 2'd1));  // Leaves r0 = 24
        prog.push_back(rr_word(OP_ST, 2'd0, 2'd2));
        prog.push_back(HALT_WORD);
        load_program();
        run_program();
        check_mem(8'd24, 8'd7);
        // Only lands at 24 with a zero when r0, r2 and r3 were cleared
        prog.delete();
        prog.push_back({OP_LI, 6'd24});
        prog.push_back(rr_word(OP_ADD, 2'd0, 2'd1));
        prog.push_back(rr_word(OP_ADD, 2'd2, 2'd3));
        prog.push_back(rr_word(OP_ST, 2'd0, 2'd2));
        prog.push_back(HALT_WORD);
        load_program();
        run_program();
        check_mem(8'd24, 8'd0);
    endtask

    task automatic load_protect();
        prog.delete();
        build_count_loop(6'd20, 6'd20);
        prog.push_back(HALT_WORD);
        load_program();
        pulse_start();
        for (int i = 0; i < prog.size(); i++) begin
            prog_we   = 1'b1;  // Overwrite with HALT mid-run
            prog_addr = pc_t'(i);
            prog_data = HALT_WORD;
            next_cycle();
        end
        prog_we = 1'b0;
        wait_done();
        check_mem(8'd20, 8'd20);  // Full count, nothing replaced
    endtask

    task automatic random_operands();
        logic [5:0] a;
        logic [5:0] b;
        for (int k = 0; k < 20; k++) begin
            a = 6'($urandom());
            b = 6'($urandom());
            prog.delete();
            append_op_store(OP_ADD, a, b, 6'd30);
            append_op_store(OP_SUB, a, b, 6'd31);
            prog.push_back(HALT_WORD);
            load_program();
            run_program();
            check_mem(8'd30, sext6(a) + sext6(b));
            check_mem(8'd31, sext6(a) - sext6(b));
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        host_addr = '0;
        void'($urandom(32'h501308ba));
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
        reset_and_halt();
        arithmetic_ops();
        memory_copy();
        branch_loop();
        restart_clear();
        load_protect();
        random_operands();
        $display("cpu_tb finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 100  // Clock period in time units
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;  // 50 high, 50 low

endmodule
